// ==== Bender.yml ====
package:
  name: iob_wb_subsys

sources:
  # Design sources in compile order
  - files:
      - iob_wb_pkg.sv
      - iob_req_buffer.sv
      - iob_iob2wishbone.sv
      - wb_sram.sv
      - iob_wb_subsys.sv

  # Testbench, top module tb_iob_wb_subsys
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_iob_wb_subsys.sv

// ==== all.f ====
iob_wb_pkg.sv
iob_req_buffer.sv
iob_iob2wishbone.sv
wb_sram.sv
iob_wb_subsys.sv
tb_clk_gen.sv
tb_iob_wb_subsys.sv

// ==== iob_iob2wishbone.sv ====
// ==========================================================================
// IOb to Wishbone classic bridge
// One bus cycle per IOb request, read data returned as a response pulse
// ==========================================================================

`timescale 1ns/1ps

module iob_iob2wishbone #(
   parameter int ADDR_W     = iob_wb_pkg::ADDR_W,
   parameter int DATA_W     = iob_wb_pkg::DATA_W,
   parameter int READ_BYTES = iob_wb_pkg::READ_BYTES
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   // IOb side
   input  logic                  iob_valid_i,
   input  logic [ADDR_W-1:0]     iob_addr_i,
   input  logic [DATA_W-1:0]     iob_wdata_i,
   input  logic [DATA_W/8-1:0]   iob_wstrb_i,
   output logic                  iob_ready_o,
   output logic                  iob_rvalid_o,
   output logic [DATA_W-1:0]     iob_rdata_o,

   // Wishbone master side
   output logic [ADDR_W-1:0]     wb_addr_o,
   output logic [DATA_W/8-1:0]   wb_select_o,
   output logic                  wb_we_o,
   output logic                  wb_cyc_o,
   output logic                  wb_stb_o,
   output logic [DATA_W-1:0]     wb_data_o,
   input  logic                  wb_ack_i,
   input  logic [DATA_W-1:0]     wb_data_i
);

   localparam int STRB_W = DATA_W / 8;
   localparam logic [STRB_W-1:0] RB_MASK = STRB_W'((1 << READ_BYTES) - 1);

   logic              we;
   logic [STRB_W-1:0] select;

   logic              pending_q;
   logic              ack_q;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdata_q;
   logic [STRB_W-1:0] select_q;
   logic              we_q;
   logic [DATA_W-1:0] rdata_q;

   // All-zero strobe means read
   assign we     = |iob_wstrb_i;
   assign select = we ? iob_wstrb_i : (RB_MASK << iob_addr_i[1:0]);

   // Live request in the accept cycle, held copy afterwards
   assign wb_addr_o   = iob_valid_i ? iob_addr_i  : addr_q;
   assign wb_data_o   = iob_valid_i ? iob_wdata_i : wdata_q;
   assign wb_select_o = iob_valid_i ? select      : select_q;
   assign wb_we_o     = iob_valid_i ? we          : we_q;
   assign wb_cyc_o    = iob_valid_i | pending_q;
   assign wb_stb_o    = wb_cyc_o;

   assign iob_ready_o  = ~pending_q;
   assign iob_rvalid_o = ack_q & ~we_q;
   assign iob_rdata_o  = rdata_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pending_q <= 1'b0;
         ack_q     <= 1'b0;
      end else begin
         ack_q <= wb_ack_i;
         if (wb_ack_i) begin
            pending_q <= 1'b0;
         end else if (iob_valid_i) begin
            pending_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (iob_valid_i) begin
         addr_q   <= iob_addr_i;
         wdata_q  <= iob_wdata_i;
         select_q <= select;
         we_q     <= we;
      end
      // Capture read word at the acknowledge
      if (wb_ack_i) begin
         rdata_q <= wb_data_i;
      end
   end

endmodule

// ==== iob_req_buffer.sv ====
// ==========================================================================
// IOb request queue
// Holds incoming requests and issues them one at a time to the bridge
// ==========================================================================

`timescale 1ns/1ps

module iob_req_buffer #(
   parameter int BUF_DEPTH = 4,
   parameter int ADDR_W    = iob_wb_pkg::ADDR_W,
   parameter int DATA_W    = iob_wb_pkg::DATA_W
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   // External request port
   input  logic                  req_valid_i,
   input  logic [ADDR_W-1:0]     req_addr_i,
   input  logic [DATA_W-1:0]     req_wdata_i,
   input  logic [DATA_W/8-1:0]   req_wstrb_i,
   output logic                  req_ready_o,

   // Towards the bridge
   output logic                  iob_valid_o,
   output logic [ADDR_W-1:0]     iob_addr_o,
   output logic [DATA_W-1:0]     iob_wdata_o,
   output logic [DATA_W/8-1:0]   iob_wstrb_o,
   input  logic                  iob_ready_i
);

   localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int CNT_W = $clog2(BUF_DEPTH + 1);

   logic [ADDR_W-1:0]   addr_q  [BUF_DEPTH];
   logic [DATA_W-1:0]   wdata_q [BUF_DEPTH];
   logic [DATA_W/8-1:0] wstrb_q [BUF_DEPTH];

   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push;
   logic             pop;

   assign req_ready_o = (count_q != CNT_W'(BUF_DEPTH));
   assign push        = req_valid_i & req_ready_o;

   // Head goes out only when the bridge can take it
   assign iob_valid_o = (count_q != '0) & iob_ready_i;
   assign pop         = iob_valid_o;

   assign iob_addr_o  = addr_q[rd_ptr_q];
   assign iob_wdata_o = wdata_q[rd_ptr_q];
   assign iob_wstrb_o = wstrb_q[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (push) begin
         addr_q[wr_ptr_q]  <= req_addr_i;
         wdata_q[wr_ptr_q] <= req_wdata_i;
         wstrb_q[wr_ptr_q] <= req_wstrb_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            // Wrap for depths that are not a power of two
            if (wr_ptr_q == PTR_W'(BUF_DEPTH - 1)) begin
               wr_ptr_q <= '0;
            end else begin
               wr_ptr_q <= wr_ptr_q + 1'b1;
            end
         end
         if (pop) begin
            if (rd_ptr_q == PTR_W'(BUF_DEPTH - 1)) begin
               rd_ptr_q <= '0;
            end else begin
               rd_ptr_q <= rd_ptr_q + 1'b1;
            end
         end
         if (push && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

// ==== iob_wb_pkg.sv ====
// ==========================================================================
// IOb to Wishbone subsystem shared definitions
// Bus widths and the memory controller state encoding
// ==========================================================================

package iob_wb_pkg;

   // Byte address width
   parameter int ADDR_W = 32;

   // Data word width
   parameter int DATA_W = 32;

   // Byte lanes per data word
   parameter int STRB_W = DATA_W / 8;

   // Bytes enabled on a read
   parameter int READ_BYTES = 4;

   // Wishbone memory controller states
   typedef enum logic [1:0] {
      MEM_IDLE,
      MEM_WAIT,
      MEM_ACK
   } wb_mem_state_t;

endpackage

// ==== iob_wb_subsys.sv ====
// ==========================================================================
// IOb to Wishbone subsystem top level
// Request queue, bridge and wait-state memory
// ==========================================================================

`timescale 1ns/1ps

module iob_wb_subsys #(
   parameter int BUF_DEPTH   = 4,
   parameter int WAIT_STATES = 2,
   parameter int MEM_WORDS   = 256
) (
   input  logic                          clk_i,
   input  logic                          rst_n_i,

   input  logic                          req_valid_i,
   input  logic [iob_wb_pkg::ADDR_W-1:0] req_addr_i,
   input  logic [iob_wb_pkg::DATA_W-1:0] req_wdata_i,
   input  logic [iob_wb_pkg::STRB_W-1:0] req_wstrb_i,
   output logic                          req_ready_o,

   output logic                          rsp_valid_o,
   output logic [iob_wb_pkg::DATA_W-1:0] rsp_rdata_o
);

   import iob_wb_pkg::*;

   // Queue to bridge
   logic              iob_valid;
   logic [ADDR_W-1:0] iob_addr;
   logic [DATA_W-1:0] iob_wdata;
   logic [STRB_W-1:0] iob_wstrb;
   logic              iob_ready;

   // Bridge to memory
   logic [ADDR_W-1:0] wb_addr;
   logic [STRB_W-1:0] wb_select;
   logic              wb_we;
   logic              wb_cyc;
   logic              wb_stb;
   logic [DATA_W-1:0] wb_data_w;
   logic              wb_ack;
   logic [DATA_W-1:0] wb_data_r;

   iob_req_buffer #(
      .BUF_DEPTH(BUF_DEPTH),
      .ADDR_W   (ADDR_W),
      .DATA_W   (DATA_W)
   ) u_buf (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .req_valid_i(req_valid_i),
      .req_addr_i (req_addr_i),
      .req_wdata_i(req_wdata_i),
      .req_wstrb_i(req_wstrb_i),
      .req_ready_o(req_ready_o),
      .iob_valid_o(iob_valid),
      .iob_addr_o (iob_addr),
      .iob_wdata_o(iob_wdata),
      .iob_wstrb_o(iob_wstrb),
      .iob_ready_i(iob_ready)
   );

   iob_iob2wishbone #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .READ_BYTES(READ_BYTES)
   ) u_bridge (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .iob_valid_i (iob_valid),
      .iob_addr_i  (iob_addr),
      .iob_wdata_i (iob_wdata),
      .iob_wstrb_i (iob_wstrb),
      .iob_ready_o (iob_ready),
      .iob_rvalid_o(rsp_valid_o),
      .iob_rdata_o (rsp_rdata_o),
      .wb_addr_o   (wb_addr),
      .wb_select_o (wb_select),
      .wb_we_o     (wb_we),
      .wb_cyc_o    (wb_cyc),
      .wb_stb_o    (wb_stb),
      .wb_data_o   (wb_data_w),
      .wb_ack_i    (wb_ack),
      .wb_data_i   (wb_data_r)
   );

   wb_sram #(
      .WAIT_STATES(WAIT_STATES),
      .MEM_WORDS  (MEM_WORDS),
      .ADDR_W     (ADDR_W),
      .DATA_W     (DATA_W)
   ) u_mem (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wb_addr_i  (wb_addr),
      .wb_select_i(wb_select),
      .wb_we_i    (wb_we),
      .wb_cyc_i   (wb_cyc),
      .wb_stb_i   (wb_stb),
      .wb_data_i  (wb_data_w),
      .wb_ack_o   (wb_ack),
      .wb_data_o  (wb_data_r)
   );

endmodule

// ==== tb_clk_gen.sv ====
// ==========================================================================
// Testbench clock and reset source
// Free-running clock, active-low reset held for a few cycles
// ==========================================================================

`timescale 1ns/1ps

module tb_clk_gen #(
   parameter real PERIOD_NS    = 10.0,
   parameter int  RESET_CYCLES = 2
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

// ==== tb_iob_wb_subsys.sv ====
// ==========================================================================
// IOb to Wishbone subsystem testbench
// Random requests, shadow memory model and response assertions
// ==========================================================================

`timescale 1ns/1ps

module tb_iob_wb_subsys;

   import iob_wb_pkg::*;

   localparam int TEST_WORDS  = 16;
   localparam int SEND_LIMIT  = 100;
   localparam int DRAIN_LIMIT = 200;
   localparam int RESET_LIMIT = 20;
   localparam int BURST_LEN   = 12;
   localparam int MIX_LEN     = 200;

   logic              clk;
   logic              rst_n;
   logic              req_valid_i;
   logic [ADDR_W-1:0] req_addr_i;
   logic [DATA_W-1:0] req_wdata_i;
   logic [STRB_W-1:0] req_wstrb_i;
   logic              req_ready_o;
   logic              rsp_valid_o;
   logic [DATA_W-1:0] rsp_rdata_o;

   // Reference model state
   logic [DATA_W-1:0] shadow [256];
   logic [DATA_W-1:0] exp_q [$];
   logic [DATA_W-1:0] exp_head;
   int                exp_count;

   logic        burst_arm;
   logic        burst_chk;
   logic        saw_backpressure;
   logic        drain_chk;
   logic [31:0] lfsr_state;

   tb_clk_gen #(
      .PERIOD_NS   (10.0),
      .RESET_CYCLES(2)
   ) u_clk_gen (
      .clk_o  (clk),
      .rst_n_o(rst_n)
   );

   iob_wb_subsys #(
      .BUF_DEPTH  (4),
      .WAIT_STATES(2),
      .MEM_WORDS  (256)
   ) u_dut (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .req_valid_i(req_valid_i),
      .req_addr_i (req_addr_i),
      .req_wdata_i(req_wdata_i),
      .req_wstrb_i(req_wstrb_i),
      .req_ready_o(req_ready_o),
      .rsp_valid_o(rsp_valid_o),
      .rsp_rdata_o(rsp_rdata_o)
   );

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("Test failures found");
      $fatal(1);
   endtask

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v          = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic [DATA_W-1:0] fill_pattern(input logic [ADDR_W-1:0] addr);
      return (addr * 32'h9e37_79b9) ^ 32'h3c5a_a5c3;
   endfunction

   // Offer one request and hold it until it is taken
   task automatic send_req(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb);
      int waited;
      waited = 0;
      req_valid_i <= 1'b1;
      req_addr_i  <= addr;
      req_wdata_i <= data;
      req_wstrb_i <= strb;
      @(posedge clk);
      while (!req_ready_o) begin
         if (waited >= SEND_LIMIT) begin
            stop_run($sformatf("timeout: request to address 0x%08h was never accepted", addr));
         end else begin
            @(posedge clk);
            waited++;
         end
      end
   endtask

   task automatic end_req();
      req_valid_i <= 1'b0;
      req_wstrb_i <= '0;
   endtask

   // Wait until queue, bus and response port have been quiet for a few cycles
   task automatic wait_drain(input string what);
      int waited;
      int quiet;
      waited = 0;
      quiet  = 0;
      while (quiet < 3) begin
         if (waited >= DRAIN_LIMIT) begin
            stop_run($sformatf("timeout: DUT did not drain after the %s", what));
         end else begin
            @(posedge clk);
            waited++;
            if (u_dut.u_buf.count_q == 0 && !u_dut.wb_cyc && !rsp_valid_o) begin
               quiet++;
            end else begin
               quiet = 0;
            end
         end
      end
      drain_chk <= 1'b1;
      @(posedge clk);
      drain_chk <= 1'b0;
   endtask

   // Shadow memory and expected read responses
   always @(posedge clk) begin : model
      int idx;
      if (!rst_n) begin
         exp_count        <= 0;
         exp_head         <= '0;
         saw_backpressure <= 1'b0;
      end else begin
         if (req_valid_i && req_ready_o) begin
            idx = int'(req_addr_i[9:2]);
            if (req_wstrb_i == '0) begin
               exp_q.push_back(shadow[idx]);
            end else begin
               for (int b = 0; b < STRB_W; b++) begin
                  if (req_wstrb_i[b]) begin
                     shadow[idx][b*8 +: 8] = req_wdata_i[b*8 +: 8];
                  end
               end
            end
         end
         if (rsp_valid_o && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
         end
         exp_count <= exp_q.size();
         exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
         if (!burst_arm) begin
            saw_backpressure <= 1'b0;
         end else if (!req_ready_o) begin
            saw_backpressure <= 1'b1;
         end
      end
   end

   a_reset_state: assert property (@(posedge clk) $rose(rst_n) |-> (req_ready_o && !rsp_valid_o))
      else stop_run($sformatf("error at %0t: after reset ready=%b rsp_valid=%b", $time,
                              $sampled(req_ready_o), $sampled(rsp_valid_o)));

   a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
                                    rsp_valid_o |-> exp_count > 0)
      else stop_run($sformatf("error at %0t: response 0x%08h with no read outstanding",
                              $time, $sampled(rsp_rdata_o)));

   a_rsp_data: assert property (@(posedge clk) disable iff (!rst_n)
                                (rsp_valid_o && exp_count > 0) |-> rsp_rdata_o == exp_head)
      else stop_run($sformatf("error at %0t: read data 0x%08h, expected 0x%08h", $time,
                              $sampled(rsp_rdata_o), $sampled(exp_head)));

   a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
                                    burst_chk |-> saw_backpressure)
      else stop_run($sformatf("error at %0t: req_ready_o never fell during the burst", $time));

   a_drained: assert property (@(posedge clk) disable iff (!rst_n)
                               drain_chk |-> exp_count == 0)
      else stop_run($sformatf("error at %0t: %0d read responses missing after drain", $time,
                              $sampled(exp_count)));

   initial begin
      int waited;
      lfsr_state  = 32'hb6ad_8309;
      req_valid_i = 1'b0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      req_wstrb_i = '0;
      burst_arm   = 1'b0;
      burst_chk   = 1'b0;
      drain_chk   = 1'b0;
      waited      = 0;
      while (rst_n !== 1'b1) begin
         if (waited >= RESET_LIMIT) begin
            stop_run("timeout: reset was never released");
         end else begin
            @(posedge clk);
            waited++;
         end
      end
      @(posedge clk);

      // Known contents for every word the tests touch
      for (int w = 0; w < TEST_WORDS; w++) begin
         send_req(ADDR_W'(w * 4), fill_pattern(ADDR_W'(w * 4)), 4'hf);
      end
      end_req();
      wait_drain("memory fill");

      send_req(32'h14, 32'hdead_beef, 4'hf);
      send_req(32'h14, 32'h0, 4'h0);
      end_req();
      wait_drain("write and read back");

      // Byte merge on one word
      send_req(32'h20, 32'h1122_3344, 4'hf);
      send_req(32'h20, 32'haabb_ccdd, 4'b0101);
      send_req(32'h20, 32'h5566_7788, 4'b1000);
      send_req(32'h20, 32'h0, 4'h0);
      end_req();
      wait_drain("partial writes");

      burst_arm <= 1'b1;
      for (int i = 0; i < BURST_LEN; i++) begin
         logic [ADDR_W-1:0] addr;
         logic [DATA_W-1:0] data;
         addr = rand_bits(4) << 2;
         data = rand_bits(32);
         send_req(addr, data, (i % 3 == 2) ? 4'h0 : 4'hf);
      end
      end_req();
      burst_chk <= 1'b1;
      @(posedge clk);
      burst_chk <= 1'b0;
      burst_arm <= 1'b0;
      wait_drain("request burst");

      for (int i = 0; i < MIX_LEN; i++) begin
         logic [STRB_W-1:0] strb;
         logic [ADDR_W-1:0] addr;
         logic [DATA_W-1:0] data;
         addr = rand_bits(4) << 2;
         data = rand_bits(32);
         strb = rand_bits(1) ? 4'h0 : STRB_W'(rand_bits(4));
         send_req(addr, data, strb);
         // Occasional gaps vary the queue occupancy
         if (rand_bits(2) == 0) begin
            end_req();
            @(posedge clk);
         end
      end
      end_req();
      wait_drain("random mix");

      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== wb_sram.sv ====
// ==========================================================================
// Wishbone classic slave memory
// Byte-select writes, acknowledge after a fixed number of wait states
// ==========================================================================

`timescale 1ns/1ps

module wb_sram #(
   parameter int WAIT_STATES = 2,
   parameter int MEM_WORDS   = 256,
   parameter int ADDR_W      = iob_wb_pkg::ADDR_W,
   parameter int DATA_W      = iob_wb_pkg::DATA_W
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   input  logic [ADDR_W-1:0]     wb_addr_i,
   input  logic [DATA_W/8-1:0]   wb_select_i,
   input  logic                  wb_we_i,
   input  logic                  wb_cyc_i,
   input  logic                  wb_stb_i,
   input  logic [DATA_W-1:0]     wb_data_i,
   output logic                  wb_ack_o,
   output logic [DATA_W-1:0]     wb_data_o
);

   import iob_wb_pkg::*;

   localparam int BYTES = DATA_W / 8;
   localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
   localparam int CNT_W = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;

   logic [DATA_W-1:0] mem [MEM_WORDS];

   wb_mem_state_t     state_q;
   logic [CNT_W-1:0]  wait_cnt_q;
   logic [IDX_W-1:0]  word_idx;

   // Word index from the byte address
   assign word_idx  = wb_addr_i[IDX_W+1:2];
   assign wb_ack_o  = (state_q == MEM_ACK);
   assign wb_data_o = mem[word_idx];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= MEM_IDLE;
         wait_cnt_q <= '0;
      end else begin
         case (state_q)
            MEM_IDLE: begin
               wait_cnt_q <= '0;
               if (wb_cyc_i && wb_stb_i) begin
                  state_q <= (WAIT_STATES == 0) ? MEM_ACK : MEM_WAIT;
               end
            end
            MEM_WAIT: begin
               wait_cnt_q <= wait_cnt_q + 1'b1;
               if (wait_cnt_q == CNT_W'(WAIT_STATES - 1)) begin
                  state_q <= MEM_ACK;
               end
            end
            MEM_ACK: begin
               state_q <= MEM_IDLE;
            end
            default: begin
               state_q <= MEM_IDLE;
            end
         endcase
      end
   end

   // Write lands on the acknowledge edge
   always_ff @(posedge clk_i) begin
      if (state_q == MEM_ACK && wb_we_i) begin
         for (int b = 0; b < BYTES; b++) begin
            if (wb_select_i[b]) begin
               mem[word_idx][b*8 +: 8] <= wb_data_i[b*8 +: 8];
            end
         end
      end
   end

endmodule
